// File: rtl/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

////////////////////
// cache geometry //
////////////////////

// byte address and data word, front end and memory alike
`define ADDR_W 32
`define DATA_W 32

// direct mapped, 16 lines of 4 words
`define LINE_OFF_W 4  // line index bits
`define WORD_OFF_W 2  // word in line bits

////////////////////
// status space   //
////////////////////

`define CNT_W 32      // hit/miss counter width

// top address bit picks the status registers
`define CTRL_SEL_BIT 31

`endif

// File: rtl/cache_types_pkg.sv
`include "cache_cfg.svh"

package cache_types_pkg;

   // bus side
   typedef logic [`ADDR_W-1:0]   addr_t;   // byte address
   typedef logic [`DATA_W-1:0]   word_t;   // data word
   typedef logic [`DATA_W/8-1:0] sel_t;    // one bit per byte lane

   // address fields seen by the store
   typedef logic [`ADDR_W-`LINE_OFF_W-`WORD_OFF_W-1:0] tag_t;
   typedef logic [`LINE_OFF_W-1:0] line_t;  // line index
   typedef logic [`WORD_OFF_W-1:0] woff_t;  // word within line

   // statistics
   typedef logic [`CNT_W-1:0] cnt_t;

endpackage

// File: rtl/cache_ctrl_pkg.sv
package cache_ctrl_pkg;

   // controller states
   typedef enum logic [2:0]
   {
      IDLE,    // wait for cyc & stb
      LOOKUP,  // tag compare result available
      REFILL,  // line fill in progress
      WTHRU,   // single word write to memory
      CSR,     // status register access
      ACK      // ack out, wait for stb low
   } fsm_state_t;

   // status word offset
   // 0 rd hit, 1 rd miss, 2 wr hit, 3 wr miss
   // wr 4 invalidates all, wr 5 clears counters
   typedef logic [2:0] csr_off_t;

endpackage

// File: rtl/wb_front_end.sv
`timescale 1ns/10ps

module wb_front_end
   import cache_types_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   // wishbone classic slave
   input  logic  cyc,
   input  logic  stb,
   input  logic  we,
   input  addr_t adr,
   input  word_t dat_w,
   input  sel_t  sel,
   output word_t dat_r,
   output logic  ack,
   // from controller
   input  logic  accept,
   input  logic  ack_set,
   input  logic  rdata_src,   // 1 = status regs
   input  word_t hit_rdata,
   input  word_t csr_rdata,
   // latched request
   output logic  req_valid,
   output logic  req_we,
   output addr_t req_addr,
   output word_t req_wdata,
   output sel_t  req_sel
);

   addr_t adr_q;

   assign req_valid = cyc & stb;

   // on accept the store sees the live address, so its lookup
   // is registered on the same edge that latches the request
   assign req_addr = accept ? adr : adr_q;

   // request payload
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         adr_q     <= adr;
         req_we    <= we;
         req_wdata <= dat_w;
         req_sel   <= sel;
      end
   end

   // ack is one cycle wide, from the controller strobe
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         ack <= 1'b0;
      else
         ack <= ack_set;
   end

   // read data, held until the next ack
   always_ff @(posedge clk)
   begin
      if (ack_set)
         dat_r <= rdata_src ? csr_rdata : hit_rdata;
   end

endmodule

// File: rtl/cache_store.sv
`timescale 1ns/10ps
`include "cache_cfg.svh"

module cache_store
   import cache_types_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   // request
   input  addr_t req_addr,
   input  word_t req_wdata,
   input  sel_t  req_sel,
   input  logic  wr_hit_we,   // byte merge on write hit
   // refill beats
   input  logic  fill_we,
   input  woff_t fill_woff,
   input  word_t fill_word,
   input  logic  inv_all,     // flash invalidate
   // lookup result
   output logic  hit,
   output word_t hit_rdata
);

   localparam int BYTE_W  = $clog2(`DATA_W/8);
   localparam int TAG_LSB = BYTE_W + `WORD_OFF_W + `LINE_OFF_W;
   localparam int N_LINES = 2**`LINE_OFF_W;
   localparam int N_WORDS = 2**(`LINE_OFF_W+`WORD_OFF_W);

   ////////////////////
   // arrays
   ////////////////////

   word_t              data_mem [N_WORDS];
   tag_t               tag_mem  [N_LINES];
   logic [N_LINES-1:0] valid;

   line_t req_line;
   woff_t req_woff;
   tag_t  req_tag;

   // address split: tag | line | word | byte
   assign req_line = req_addr[BYTE_W+`WORD_OFF_W +: `LINE_OFF_W];
   assign req_woff = req_addr[BYTE_W +: `WORD_OFF_W];
   assign req_tag  = tag_t'(req_addr >> TAG_LSB);  // upper bits zero

   // data and tag writes
   always_ff @(posedge clk)
   begin
      if (fill_we)
      begin
         data_mem[{req_line, fill_woff}] <= fill_word;
         if (fill_woff == '1)
            tag_mem[req_line] <= req_tag;  // tag lands with last word
      end
      else if (wr_hit_we)
      begin
         for (int b = 0; b < `DATA_W/8; b++)
         begin
            if (req_sel[b])
               data_mem[{req_line, req_woff}][8*b +: 8] <= req_wdata[8*b +: 8];
         end
      end
   end

   // valid bits
   always_ff @(posedge clk)
   begin
      if (!rst_n || inv_all)
         valid <= '0;                     // all lines in one cycle
      else if (fill_we && fill_woff == '1)
         valid[req_line] <= 1'b1;         // line complete
   end

   ////////////////////
   // synchronous lookup
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         hit <= 1'b0;
      else
         hit <= valid[req_line] && (tag_mem[req_line] == req_tag);
   end

   always_ff @(posedge clk)
   begin
      hit_rdata <= data_mem[{req_line, req_woff}];
   end

endmodule

// File: rtl/mem_back_end.sv
`timescale 1ns/10ps
`include "cache_cfg.svh"

module mem_back_end
   import cache_types_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   // from controller
   input  logic  refill_start,
   input  logic  wthru_start,
   input  addr_t req_addr,
   input  word_t req_wdata,
   input  sel_t  req_sel,
   // native memory master
   output logic  mem_valid,
   output addr_t mem_addr,
   output word_t mem_wdata,
   output sel_t  mem_wstrb,
   input  word_t mem_rdata,
   input  logic  mem_ready,
   // to store
   output logic  fill_we,
   output woff_t fill_woff,
   output word_t fill_word,
   output logic  be_done      // one cycle after last ready
);

   localparam int BYTE_W = $clog2(`DATA_W/8);
   localparam int LINE_LSB = BYTE_W + `WORD_OFF_W;

   logic  refilling;   // 1 = line fill, 0 = write-through
   woff_t word_cnt;    // current beat
   logic  xfer;

   assign xfer = mem_valid & mem_ready;

   // refill beats go straight into the store
   assign fill_we   = xfer & refilling;
   assign fill_woff = word_cnt;
   assign fill_word = mem_rdata;

   ////////////////////
   // control
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         mem_valid <= 1'b0;
         be_done   <= 1'b0;
         refilling <= 1'b0;
         word_cnt  <= '0;
      end
      else
      begin
         be_done <= 1'b0;                 // pulse by default
         if (refill_start)
         begin
            mem_valid <= 1'b1;
            refilling <= 1'b1;
            word_cnt  <= '0;              // start at word 0
         end
         else if (wthru_start)
         begin
            mem_valid <= 1'b1;
            refilling <= 1'b0;
         end
         else if (xfer)
         begin
            if (refilling && word_cnt != '1)
               word_cnt <= word_cnt + 2'd1;  // next beat, keep valid
            else
            begin
               mem_valid <= 1'b0;
               be_done   <= 1'b1;
            end
         end
      end
   end

   ////////////////////
   // request fields, held while stalled
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (refill_start)
      begin
         mem_addr  <= {req_addr[`ADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}};  // line base
         mem_wstrb <= '0;                 // read
      end
      else if (wthru_start)
      begin
         mem_addr  <= {req_addr[`ADDR_W-1:BYTE_W], {BYTE_W{1'b0}}};
         mem_wdata <= req_wdata;
         mem_wstrb <= req_sel;
      end
      else if (xfer && refilling)
         mem_addr[LINE_LSB-1:BYTE_W] <= word_cnt + 2'd1;  // walk the line
   end

endmodule

// File: rtl/cache_status.sv
`timescale 1ns/10ps

module cache_status
   import cache_types_pkg::*;
   import cache_ctrl_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic [3:0] cnt_inc,    // rd hit, rd miss, wr hit, wr miss
   input  logic       cnt_clr,
   input  csr_off_t   csr_off,
   output word_t      csr_rdata
);

   cnt_t cnt [4];

   ////////////////////
   // counters
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (!rst_n || cnt_clr)
      begin
         for (int i = 0; i < 4; i++)
            cnt[i] <= '0;
      end
      else
      begin
         for (int i = 0; i < 4; i++)
         begin
            if (cnt_inc[i] && cnt[i] != '1)
               cnt[i] <= cnt[i] + cnt_t'(1);  // saturate at all ones
         end
      end
   end

   // offsets 4..7 are write-only commands, read as zero
   assign csr_rdata = csr_off[2] ? '0 : cnt[csr_off[1:0]];

endmodule

// File: rtl/cache_fsm.sv
`timescale 1ns/10ps
`include "cache_cfg.svh"

module cache_fsm
   import cache_types_pkg::*;
   import cache_ctrl_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       req_valid,
   input  logic       req_we,
   input  addr_t      req_addr,
   input  logic       hit,
   input  logic       be_done,
   input  logic       stb,
   output logic       accept,
   output logic       ack_set,
   output logic       rdata_src,
   output logic       wr_hit_we,
   output logic       inv_all,
   output logic       refill_start,
   output logic       wthru_start,
   output logic [3:0] cnt_inc,
   output logic       cnt_clr,
   output csr_off_t   csr_off
);

   fsm_state_t state, state_nxt;
   logic       refilled;   // second lookup after a fill, not counted

   assign csr_off = req_addr[4:2];  // word offset in status space

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state    <= IDLE;
         refilled <= 1'b0;
      end
      else
      begin
         state <= state_nxt;
         if (state == IDLE)
            refilled <= 1'b0;
         else if (state == REFILL)
            refilled <= 1'b1;
      end
   end

   ////////////////////
   // next state, strobes
   ////////////////////

   always_comb
   begin
      state_nxt    = state;
      accept       = 1'b0;
      ack_set      = 1'b0;
      rdata_src    = 1'b0;
      wr_hit_we    = 1'b0;
      inv_all      = 1'b0;
      refill_start = 1'b0;
      wthru_start  = 1'b0;
      cnt_inc      = 4'b0000;
      cnt_clr      = 1'b0;
      case (state)
         IDLE:
         begin
            if (req_valid)
            begin
               accept    = 1'b1;
               state_nxt = req_addr[`CTRL_SEL_BIT] ? CSR : LOOKUP;
            end
         end
         LOOKUP:
         begin
            if (req_we)
            begin
               cnt_inc     = hit ? 4'b0100 : 4'b1000;
               wr_hit_we   = hit;      // no allocate on miss
               wthru_start = 1'b1;
               state_nxt   = WTHRU;
            end
            else if (hit)
            begin
               cnt_inc[0] = !refilled;
               ack_set    = 1'b1;
               state_nxt  = ACK;
            end
            else
            begin
               cnt_inc[1]   = 1'b1;
               refill_start = 1'b1;
               state_nxt    = REFILL;
            end
         end
         REFILL:
         begin
            if (be_done)
               state_nxt = LOOKUP;     // relook, now hits
         end
         WTHRU:
         begin
            if (be_done)
            begin
               ack_set   = 1'b1;
               state_nxt = ACK;
            end
         end
         CSR:
         begin
            ack_set   = 1'b1;
            rdata_src = 1'b1;
            inv_all   = req_we && csr_off == 3'd4;
            cnt_clr   = req_we && csr_off == 3'd5;
            state_nxt = ACK;
         end
         ACK:
         begin
            if (!stb)
               state_nxt = IDLE;       // master has dropped the strobe
         end
         default:
            state_nxt = IDLE;
      endcase
   end

endmodule

// File: rtl/wb_cache_top.sv
`timescale 1ns/10ps

module wb_cache_top
   import cache_types_pkg::*;
   import cache_ctrl_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   // wishbone classic slave
   input  logic  cyc,
   input  logic  stb,
   input  logic  we,
   input  addr_t adr,
   input  word_t dat_w,
   input  sel_t  sel,
   output word_t dat_r,
   output logic  ack,
   // native memory master
   output logic  mem_valid,
   output addr_t mem_addr,
   output word_t mem_wdata,
   output sel_t  mem_wstrb,
   input  word_t mem_rdata,
   input  logic  mem_ready
);

   // latched request
   logic       req_valid, req_we;
   addr_t      req_addr;
   word_t      req_wdata;
   sel_t       req_sel;
   // controller strobes
   logic       accept, ack_set, rdata_src, wr_hit_we, inv_all;
   logic       refill_start, wthru_start, cnt_clr;
   logic [3:0] cnt_inc;
   csr_off_t   csr_off;
   // datapath returns
   logic       hit, be_done, fill_we;
   word_t      hit_rdata, csr_rdata, fill_word;
   woff_t      fill_woff;

   wb_front_end front_end
   (
      .clk(clk), .rst_n(rst_n),
      .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w), .sel(sel),
      .dat_r(dat_r), .ack(ack),
      .accept(accept), .ack_set(ack_set), .rdata_src(rdata_src),
      .hit_rdata(hit_rdata), .csr_rdata(csr_rdata),
      .req_valid(req_valid), .req_we(req_we), .req_addr(req_addr),
      .req_wdata(req_wdata), .req_sel(req_sel)
   );

   cache_store store
   (
      .clk(clk), .rst_n(rst_n),
      .req_addr(req_addr), .req_wdata(req_wdata), .req_sel(req_sel),
      .wr_hit_we(wr_hit_we), .fill_we(fill_we), .fill_woff(fill_woff),
      .fill_word(fill_word), .inv_all(inv_all),
      .hit(hit), .hit_rdata(hit_rdata)
   );

   mem_back_end back_end
   (
      .clk(clk), .rst_n(rst_n),
      .refill_start(refill_start), .wthru_start(wthru_start),
      .req_addr(req_addr), .req_wdata(req_wdata), .req_sel(req_sel),
      .mem_valid(mem_valid), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
      .mem_wstrb(mem_wstrb), .mem_rdata(mem_rdata), .mem_ready(mem_ready),
      .fill_we(fill_we), .fill_woff(fill_woff), .fill_word(fill_word),
      .be_done(be_done)
   );

   cache_status status
   (
      .clk(clk), .rst_n(rst_n),
      .cnt_inc(cnt_inc), .cnt_clr(cnt_clr), .csr_off(csr_off),
      .csr_rdata(csr_rdata)
   );

   cache_fsm fsm
   (
      .clk(clk), .rst_n(rst_n),
      .req_valid(req_valid), .req_we(req_we), .req_addr(req_addr),
      .hit(hit), .be_done(be_done), .stb(stb),
      .accept(accept), .ack_set(ack_set), .rdata_src(rdata_src),
      .wr_hit_we(wr_hit_we), .inv_all(inv_all),
      .refill_start(refill_start), .wthru_start(wthru_start),
      .cnt_inc(cnt_inc), .cnt_clr(cnt_clr), .csr_off(csr_off)
   );

endmodule

// File: bench/mem_model.sv
`timescale 1ns/10ps

module mem_model
   import cache_types_pkg::*;
#(
   parameter int unsigned SEED = 32'h1839
)
(
   input  logic  clk,
   // native memory slave side
   input  logic  mem_valid,
   input  addr_t mem_addr,
   input  word_t mem_wdata,
   input  sel_t  mem_wstrb,
   output word_t mem_rdata,
   output logic  mem_ready,
   // backdoor read
   input  addr_t bd_addr,
   output word_t bd_data
);

   word_t mem [1024];   // 4 KB, word indexed

   assign bd_data = mem[bd_addr[11:2]];

   initial
   begin
      int unsigned stall;
      for (int i = 0; i < 1024; i++)
         mem[i] = 32'h5a00_0000 | (i << 14) | (i << 2);  // index and byte address
      mem_ready = 1'b0;
      mem_rdata = '0;
      void'($urandom(SEED));   // one seed for every draw below
      forever
      begin
         @(negedge clk);
         mem_ready = 1'b0;
         if (mem_valid)
         begin
            stall = $urandom % 8;            // 0 to 7 idle cycles
            repeat (stall) @(negedge clk);
            if (mem_wstrb == '0)
               mem_rdata = mem[mem_addr[11:2]];
            else
            begin
               for (int b = 0; b < 4; b++)
                  if (mem_wstrb[b])
                     mem[mem_addr[11:2]][8*b +: 8] = mem_wdata[8*b +: 8];
            end
            mem_ready = 1'b1;                // valid is held, so this edge transfers
         end
      end
   end

endmodule

// File: bench/tb_cache.sv
`timescale 1ns/10ps
`include "cache_cfg.svh"

module tb_cache
   import cache_types_pkg::*;
();

   localparam int    TAG_LSB = 2 + `WORD_OFF_W + `LINE_OFF_W;
   localparam addr_t STS     = 32'h1 << `CTRL_SEL_BIT;   // status space base

   typedef enum logic [2:0] {OP_RD, OP_WR, OP_SRD, OP_INV, OP_CLR} op_t;

   typedef struct packed
   {
      op_t   op;
      addr_t addr;
      word_t data;
      sel_t  sel;
      word_t exp;   // miss flag for rd/wr, count for status reads
   } row_t;

   logic  clk = 1'b0;
   logic  rst_n;
   logic  cyc, stb, we, ack;
   addr_t adr, mem_addr, bd_addr;
   word_t dat_w, dat_r, mem_wdata, mem_rdata, bd_data;
   sel_t  sel, mem_wstrb;
   logic  mem_valid, mem_ready;

   row_t         rows [$];
   word_t        ref_mem [1024];   // memory as the model sees it
   tag_t         ref_tag [16];
   logic  [15:0] ref_valid;
   cnt_t         ref_cnt [4];       // rd hit, rd miss, wr hit, wr miss
   int           errors = 0;
   int           checks = 0;
   int           cycles = 0;
   int           cycle_limit = 0;

   always #4 clk = ~clk;   // 8 ns

   wb_cache_top DUT
   (
      .clk(clk), .rst_n(rst_n),
      .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w), .sel(sel),
      .dat_r(dat_r), .ack(ack),
      .mem_valid(mem_valid), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
      .mem_wstrb(mem_wstrb), .mem_rdata(mem_rdata), .mem_ready(mem_ready)
   );

   mem_model #(.SEED(32'h1839)) memory
   (
      .clk(clk),
      .mem_valid(mem_valid), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
      .mem_wstrb(mem_wstrb), .mem_rdata(mem_rdata), .mem_ready(mem_ready),
      .bd_addr(bd_addr), .bd_data(bd_data)
   );

   // run limit, checked every edge
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycle_limit > 0 && cycles >= cycle_limit)
      begin
         $display("timeout: the DUT did not finish the table within %0d cycles", cycles);
         $display("test failed");
         $finish;
      end
   end

   ////////////////////
   // helpers
   ////////////////////

   task automatic compare(input string name, input word_t got, input word_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // same contents the memory starts with
   function automatic word_t pattern_word(input int unsigned i);
      return 32'h5a00_0000 | (i << 14) | (i << 2);
   endfunction

   task automatic add_row(input op_t op, input addr_t a, input word_t d, input sel_t s,
                          input word_t e);
      rows.push_back('{op, a, d, s, e});
   endtask

   // one wishbone classic cycle, driven on the falling edge
   task automatic bus_cycle(input logic wr, input addr_t a, input word_t d, input sel_t s,
                            output word_t rd);
      @(negedge clk);
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = wr;
      adr   = a;
      dat_w = d;
      sel   = s;
      @(negedge clk);
      while (!ack)
         @(negedge clk);
      rd  = dat_r;
      cyc = 1'b0;   // strobe low for at least a cycle
      stb = 1'b0;
      we  = 1'b0;
   endtask

   // direct mapped shadow, reads allocate, writes never do
   task automatic model_update(input row_t r, output logic miss);
      line_t idx;
      tag_t  tg;
      idx  = r.addr[TAG_LSB-1 -: `LINE_OFF_W];
      tg   = tag_t'(r.addr >> TAG_LSB);
      miss = !(ref_valid[idx] && ref_tag[idx] == tg);
      ref_cnt[{r.op == OP_WR, miss}]++;
      if (r.op == OP_RD)
      begin
         ref_valid[idx] = 1'b1;
         ref_tag[idx]   = tg;
      end
      else
      begin
         for (int b = 0; b < 4; b++)
            if (r.sel[b])
               ref_mem[r.addr[11:2]][8*b +: 8] = r.data[8*b +: 8];
      end
   endtask

   task automatic run_row(input int n, input row_t r);
      word_t rd;
      logic  miss;
      op_t   op;
      int    err_before;
      err_before = errors;
      op = r.op;
      case (op)
         OP_RD:
         begin
            model_update(r, miss);
            bus_cycle(1'b0, r.addr, '0, '1, rd);
            compare("miss_flag", word_t'(miss), r.exp);
            compare("dat_r", rd, ref_mem[r.addr[11:2]]);
         end
         OP_WR:
         begin
            model_update(r, miss);
            bus_cycle(1'b1, r.addr, r.data, r.sel, rd);
            compare("miss_flag", word_t'(miss), r.exp);
            bd_addr = r.addr;
            #1;
            compare("mem_word", bd_data, ref_mem[r.addr[11:2]]);  // write-through landed
         end
         OP_SRD:
         begin
            bus_cycle(1'b0, r.addr, '0, '1, rd);
            compare("dat_r", rd, ref_cnt[r.addr[3:2]]);
            compare("table_count", ref_cnt[r.addr[3:2]], r.exp);
         end
         OP_INV:
         begin
            bus_cycle(1'b1, r.addr, '0, '1, rd);
            ref_valid = '0;
         end
         default:
         begin
            bus_cycle(1'b1, r.addr, '0, '1, rd);
            for (int i = 0; i < 4; i++)
               ref_cnt[i] = '0;
         end
      endcase
      $display("row %0d %s %h : %s", n, op.name(), r.addr,
               errors == err_before ? "ok" : "bad");
   endtask

   ////////////////////
   // stimulus table
   ////////////////////

   task automatic build_table();
      // line 0 fill, then the rest of the line hits
      add_row(OP_RD, 'h100, 0, 4'hf, 1);
      add_row(OP_RD, 'h104, 0, 4'hf, 0);
      add_row(OP_RD, 'h108, 0, 4'hf, 0);
      add_row(OP_RD, 'h10c, 0, 4'hf, 0);
      // partial write hit
      add_row(OP_WR, 'h104, 32'hdead_beef, 4'b0110, 0);
      add_row(OP_RD, 'h104, 0, 4'hf, 0);
      // write miss, no allocate
      add_row(OP_WR, 'h230, 32'h1234_5678, 4'hf, 1);
      add_row(OP_RD, 'h230, 0, 4'hf, 1);
      // counters, clear
      add_row(OP_SRD, STS + 0, 0, 4'hf, 4);
      add_row(OP_SRD, STS + 4, 0, 4'hf, 2);
      add_row(OP_SRD, STS + 8, 0, 4'hf, 1);
      add_row(OP_SRD, STS + 12, 0, 4'hf, 1);
      add_row(OP_CLR, STS + 20, 0, 4'hf, 0);
      add_row(OP_SRD, STS + 0, 0, 4'hf, 0);
      add_row(OP_SRD, STS + 4, 0, 4'hf, 0);
      add_row(OP_SRD, STS + 8, 0, 4'hf, 0);
      add_row(OP_SRD, STS + 12, 0, 4'hf, 0);
      // invalidate drops a cached line
      add_row(OP_RD, 'h108, 0, 4'hf, 0);
      add_row(OP_INV, STS + 16, 0, 4'hf, 0);
      add_row(OP_RD, 'h108, 0, 4'hf, 1);
      add_row(OP_RD, 'h104, 0, 4'hf, 0);
      // index 5 conflicts, three tags
      add_row(OP_RD, 'h050, 0, 4'hf, 1);
      add_row(OP_RD, 'h150, 0, 4'hf, 1);
      add_row(OP_RD, 'h054, 0, 4'hf, 1);
      add_row(OP_RD, 'h158, 0, 4'hf, 1);
      add_row(OP_RD, 'h15c, 0, 4'hf, 0);
      add_row(OP_RD, 'hf50, 0, 4'hf, 1);
      add_row(OP_WR, 'h05c, 32'hcafe_f00d, 4'b1000, 1);
      add_row(OP_RD, 'h05c, 0, 4'hf, 1);
      add_row(OP_RD, 'hf54, 0, 4'hf, 1);
      add_row(OP_SRD, STS + 0, 0, 4'hf, 3);
      add_row(OP_SRD, STS + 4, 0, 4'hf, 8);
      add_row(OP_SRD, STS + 8, 0, 4'hf, 0);
      add_row(OP_SRD, STS + 12, 0, 4'hf, 1);
   endtask

   initial
   begin
      rst_n   = 1'b0;
      cyc     = 1'b0;
      stb     = 1'b0;
      we      = 1'b0;
      adr     = '0;
      dat_w   = '0;
      sel     = '0;
      bd_addr = '0;
      for (int i = 0; i < 1024; i++)
         ref_mem[i] = pattern_word(i);
      for (int i = 0; i < 16; i++)
         ref_tag[i] = '0;
      for (int i = 0; i < 4; i++)
         ref_cnt[i] = '0;
      ref_valid = '0;
      build_table();
      cycle_limit = rows.size() * 60 + 8;   // worst refill plus overhead per row

      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      compare("ack", word_t'(ack), 0);
      compare("mem_valid", word_t'(mem_valid), 0);
      $display("reset : %s", errors == 0 ? "ok" : "bad");

      foreach (rows[n])
         run_row(n, rows[n]);

      $display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

// File: sim.f
+incdir+rtl
rtl/cache_types_pkg.sv
rtl/cache_ctrl_pkg.sv
rtl/wb_front_end.sv
rtl/cache_store.sv
rtl/mem_back_end.sv
rtl/cache_status.sv
rtl/cache_fsm.sv
rtl/wb_cache_top.sv
bench/mem_model.sv
bench/tb_cache.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary -j 0 --timescale 1ns/10ps
TOP      = tb_cache
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
